/* list.f */
+incdir+include
hw/cvita_pkg.sv
hw/axis_flop_stage.sv
hw/cvita_hdr_parser.sv
hw/cvita_beat_counter.sv
hw/cvita_status_merge.sv
hw/cvita_pkt_inspector.sv
dv/cvita_pkt_inspector_checker.sv
dv/cvita_pkt_inspector_tb.sv

/* Makefile */
# Verilator flow for the cvita packet inspector

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        := cvita_pkt_inspector_tb
RTL_TOP    := cvita_pkt_inspector
FILELIST   := list.f
LOG        := sim.log
PASS_MSG   := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/cvita_pkt_inspector_tb.sv */
////////////////////////////////////////////////////////////
// cvita packet inspector testbench
// random packets under stalls, checked beat by beat and
// record by record against a reference model
////////////////////////////////////////////////////////////
`include "cvita_consts.svh"

module cvita_pkt_inspector_tb import cvita_pkg::*; ();

  localparam int RUN1_PKTS   = 60;
  localparam int RUN2_PKTS   = 40;
  localparam int DRAIN_LIMIT = 20000;

  logic                     clk;
  logic                     i_rst_n;
  logic                     i_clear;
  logic [`CVITA_DATA_W-1:0] i_tdata;
  logic                     i_tlast;
  logic                     i_tvalid;
  logic                     o_tready;
  logic [`CVITA_DATA_W-1:0] o_tdata;
  logic                     o_tlast;
  logic                     o_tvalid;
  logic                     i_out_tready;
  logic                     o_status_valid;
  cvita_status_t            o_status;

  // beats are {last, data}
  logic [`CVITA_DATA_W:0]   in_q[$];
  logic [`CVITA_DATA_W:0]   exp_beat_q[$];
  cvita_status_t            exp_stat_q[$];
  logic [31:0]              lcg_state;
  logic [`CVITA_SEQ_W-1:0]  seq_next;
  logic [`CVITA_SEQ_W-1:0]  model_last;
  logic                     model_seen;
  logic                     in_taken;
  logic                     status_due;
  // beats accepted at the input and not yet taken at the output
  int                       in_flight;

  cvita_pkt_inspector cvita_pkt_inspector_inst (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_clear        (i_clear),
    .i_tdata        (i_tdata),
    .i_tlast        (i_tlast),
    .i_tvalid       (i_tvalid),
    .o_tready       (o_tready),
    .o_tdata        (o_tdata),
    .o_tlast        (o_tlast),
    .o_tvalid       (o_tvalid),
    .i_out_tready   (i_out_tready),
    .o_status_valid (o_status_valid),
    .o_status       (o_status)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // the low bits of an lcg repeat quickly so only the upper bits are used
  function automatic int rand_below(int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r >> 8) % n;
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////
  task automatic make_packet();
    cvita_hdr_t               hdr;
    cvita_status_t            st;
    int                       nbeats;
    logic [`CVITA_DATA_W-1:0] word;
    logic [`CVITA_DATA_W-1:0] second;
    nbeats       = 1 + rand_below(8);
    hdr.pkt_type = 2'(rand_below(4));
    hdr.has_time = 1'(rand_below(2));
    hdr.eob      = 1'(rand_below(2));
    // occasional sequence gap
    if (rand_below(8) == 0) begin
      seq_next = `CVITA_SEQ_W'(int'(seq_next) + 2 + rand_below(30));
    end
    hdr.seqnum = seq_next;
    seq_next   = `CVITA_SEQ_W'(int'(seq_next) + 1);
    if (rand_below(6) == 0) begin
      hdr.pkt_len = 16'(rand_below(80));
    end else begin
      hdr.pkt_len = 16'(nbeats * 8 - rand_below(8));
    end
    hdr.sid = lcg_next();
    second  = '0;
    for (int i = 0; i < nbeats; i++) begin
      word = (i == 0) ? hdr : {lcg_next(), lcg_next()};
      if (i == 1) begin
        second = word;
      end
      in_q.push_back({i == nbeats - 1, word});
      exp_beat_q.push_back({i == nbeats - 1, word});
    end
    st.hdr       = hdr;
    st.vita_time = (hdr.has_time && nbeats >= 2) ? second : '0;
    st.beats     = 16'(nbeats);
    st.len_err   = ((int'(hdr.pkt_len) + 7) / 8) != nbeats;
    st.time_err  = hdr.has_time && nbeats < 2;
    st.seq_err   = model_seen &&
                   (int'(hdr.seqnum) != (int'(model_last) + 1) % `CVITA_SEQ_MOD);
    model_seen   = 1'b1;
    model_last   = hdr.seqnum;
    exp_stat_q.push_back(st);
  endtask

  ////////////////////////////////////////////////////////////
  // per-cycle drive and scoreboard
  ////////////////////////////////////////////////////////////
  task automatic run_cycle();
    logic [`CVITA_DATA_W:0] word;
    cvita_status_t          exp_st;
    @(negedge clk);
    if (in_taken) begin
      i_tvalid = 1'b0;
      in_taken = 1'b0;
    end
    if (!i_tvalid && in_q.size() > 0 && rand_below(4) != 0) begin
      word     = in_q.pop_front();
      i_tlast  = word[`CVITA_DATA_W];
      i_tdata  = word[`CVITA_DATA_W-1:0];
      i_tvalid = 1'b1;
    end
    i_out_tready = (rand_below(4) != 0);
    // handshakes for the next rising edge are settled in the low phase
    #1;
    // one-entry stage holds a beat until the sink takes it
    check_value(o_tvalid, in_flight != 0, "output valid");
    check_value(o_tready, in_flight == 0 || i_out_tready, "input ready");
    check_value(o_status_valid, status_due, "status strobe timing");
    if (status_due) begin
      exp_st = exp_stat_q.pop_front();
      check_value(o_status.hdr, exp_st.hdr, "status header");
      check_value(o_status.vita_time, exp_st.vita_time, "status vita time");
      check_value(o_status.beats, exp_st.beats, "status beats");
      check_value(o_status.len_err, exp_st.len_err, "status len_err");
      check_value(o_status.time_err, exp_st.time_err, "status time_err");
      check_value(o_status.seq_err, exp_st.seq_err, "status seq_err");
    end
    status_due = 1'b0;
    if (i_tvalid && o_tready) begin
      in_taken = 1'b1;
      in_flight++;
    end
    if (o_tvalid && i_out_tready) begin
      check_value(exp_beat_q.size() > 0, 1'b1, "output beat with none expected");
      word = exp_beat_q.pop_front();
      check_value(o_tdata, word[`CVITA_DATA_W-1:0], "output data");
      check_value(o_tlast, word[`CVITA_DATA_W], "output last");
      status_due = o_tlast;
      in_flight--;
    end
  endtask

  task automatic drain(input string phase);
    int guard;
    guard = 0;
    while (in_q.size() > 0 || exp_beat_q.size() > 0 || exp_stat_q.size() > 0 ||
           status_due) begin
      run_cycle();
      guard++;
      if (guard > DRAIN_LIMIT) begin
        $display("timeout: %s did not finish within %0d cycles", phase, DRAIN_LIMIT);
        $display("Checks failed");
        $fatal(1, "stream stalled");
      end
    end
  endtask

  task automatic apply_clear();
    @(negedge clk);
    i_tvalid = 1'b0;
    in_taken = 1'b0;
    i_clear  = 1'b1;
    @(negedge clk);
    i_clear    = 1'b0;
    model_seen = 1'b0;
  endtask

  initial begin
    lcg_state    = 32'h961f_c409;
    i_rst_n      = 1'b1;
    i_clear      = 1'b0;
    i_tdata      = '0;
    i_tlast      = 1'b0;
    i_tvalid     = 1'b0;
    i_out_tready = 1'b0;
    in_taken     = 1'b0;
    status_due   = 1'b0;
    model_seen   = 1'b0;
    model_last   = '0;
    in_flight    = 0;
    // start near the top so the first run crosses the wrap
    seq_next     = `CVITA_SEQ_W'(4080 + rand_below(8));
    // drop reset after time zero so the async edge is seen
    #1;
    i_rst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;

    for (int n = 0; n < RUN1_PKTS; n++) begin
      make_packet();
    end
    drain("first run");

    // the first packet after clear starts a new sequence base
    apply_clear();
    seq_next = `CVITA_SEQ_W'(rand_below(`CVITA_SEQ_MOD));
    for (int n = 0; n < RUN2_PKTS; n++) begin
      make_packet();
    end
    drain("run after clear");

    // idle cycles catch stray beats or records
    repeat (4) run_cycle();

    $display("All checks passed");
    $finish;
  end

endmodule

/* dv/cvita_pkt_inspector_checker.sv */
////////////////////////////////////////////////////////////
// cvita inspector checker
// stream hold, status strobe and reset assertions
////////////////////////////////////////////////////////////
`include "cvita_consts.svh"

module cvita_pkt_inspector_checker (
  input logic                     clk,
  input logic                     i_rst_n,
  input logic                     i_clear,
  input logic [`CVITA_DATA_W-1:0] o_tdata,
  input logic                     o_tlast,
  input logic                     o_tvalid,
  input logic                     i_out_tready,
  input logic                     o_status_valid
);

  // a stalled beat stays put until the sink takes it
  a_stall_hold: assert property (@(posedge clk) disable iff (!i_rst_n || i_clear)
    o_tvalid && !i_out_tready |=> o_tvalid && $stable(o_tdata) && $stable(o_tlast))
    else $error("output beat dropped or changed while stalled");

  // each status strobe belongs to a last beat taken one cycle earlier
  a_status_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_status_valid |-> $past(o_tvalid && i_out_tready && o_tlast))
    else $error("status valid without a last beat one cycle before");

  a_reset_quiet: assert property (@(posedge clk)
    !i_rst_n |-> !o_tvalid && !o_status_valid)
    else $error("outputs active during reset");

endmodule

bind cvita_pkt_inspector cvita_pkt_inspector_checker u_checker (
  .clk            (clk),
  .i_rst_n        (i_rst_n),
  .i_clear        (i_clear),
  .o_tdata        (o_tdata),
  .o_tlast        (o_tlast),
  .o_tvalid       (o_tvalid),
  .i_out_tready   (i_out_tready),
  .o_status_valid (o_status_valid)
);

/* hw/cvita_pkt_inspector.sv */
////////////////////////////////////////////////////////////
// cvita packet inspector
// passes a cvita stream through and reports one status
// record per packet
////////////////////////////////////////////////////////////
`include "cvita_consts.svh"

module cvita_pkt_inspector import cvita_pkg::*; (
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  logic                     i_clear,
  input  logic [`CVITA_DATA_W-1:0] i_tdata,
  input  logic                     i_tlast,
  input  logic                     i_tvalid,
  output logic                     o_tready,
  output logic [`CVITA_DATA_W-1:0] o_tdata,
  output logic                     o_tlast,
  output logic                     o_tvalid,
  input  logic                     i_out_tready,
  output logic                     o_status_valid,
  output cvita_status_t            o_status
);

  logic                       hdr_stb;
  cvita_hdr_t                 hdr;
  logic                       time_stb;
  logic [`CVITA_DATA_W-1:0]   vita_time;
  logic                       beat;
  logic                       pkt_end;
  logic [`CVITA_LEN_W-1:0]    beats;

  // counter and merger watch the same output handshake as the parser
  assign beat = o_tvalid & i_out_tready;

  cvita_hdr_parser #(
    .REGISTER (`CVITA_HDR_REGISTER)
  ) u_parser (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_clear      (i_clear),
    .i_tdata      (i_tdata),
    .i_tlast      (i_tlast),
    .i_tvalid     (i_tvalid),
    .o_tready     (o_tready),
    .o_tdata      (o_tdata),
    .o_tlast      (o_tlast),
    .o_tvalid     (o_tvalid),
    .i_out_tready (i_out_tready),
    .o_hdr_stb    (hdr_stb),
    .o_hdr        (hdr),
    .o_time_stb   (time_stb),
    .o_vita_time  (vita_time)
  );

  cvita_beat_counter u_counter (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_clear   (i_clear),
    .i_beat    (beat),
    .i_last    (o_tlast),
    .o_pkt_end (pkt_end),
    .o_beats   (beats)
  );

  cvita_status_merge u_merge (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_clear        (i_clear),
    .i_hdr_stb      (hdr_stb),
    .i_hdr          (hdr),
    .i_time_stb     (time_stb),
    .i_vita_time    (vita_time),
    .i_pkt_end      (pkt_end),
    .i_beats        (beats),
    .o_status_valid (o_status_valid),
    .o_status       (o_status)
  );

endmodule

/* hw/cvita_status_merge.sv */
////////////////////////////////////////////////////////////
// cvita status merger
// joins parser fields and beat count into one checked
// status record per packet
////////////////////////////////////////////////////////////
`include "cvita_consts.svh"

module cvita_status_merge import cvita_pkg::*; (
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  logic                     i_clear,
  input  logic                     i_hdr_stb,
  input  cvita_hdr_t               i_hdr,
  input  logic                     i_time_stb,
  input  logic [`CVITA_DATA_W-1:0] i_vita_time,
  input  logic                     i_pkt_end,
  input  logic [`CVITA_LEN_W-1:0]  i_beats,
  output logic                     o_status_valid,
  output cvita_status_t            o_status
);

  cvita_hdr_t                 hdr_q;
  logic [`CVITA_DATA_W-1:0]   time_q;
  logic [`CVITA_SEQ_W-1:0]    last_seq;
  logic                       seq_seen;
  cvita_hdr_t                 cur_hdr;
  logic [`CVITA_DATA_W-1:0]   cur_time;
  logic [`CVITA_LEN_W:0]      len_ceil;
  logic [`CVITA_SEQ_W-1:0]    seq_expect;
  cvita_status_t              status_d;

  // a new header wipes the time left over from the last packet
  always_ff @(posedge clk) begin
    if (i_hdr_stb) begin
      hdr_q  <= i_hdr;
      time_q <= '0;
    end else if (i_time_stb) begin
      time_q <= i_vita_time;
    end
  end

  // one- and two-beat packets end on the strobe itself
  assign cur_hdr  = i_hdr_stb ? i_hdr : hdr_q;
  assign cur_time = i_time_stb ? i_vita_time : (i_hdr_stb ? '0 : time_q);

  // ceiling of bytes over 8, one bit wider to avoid overflow
  assign len_ceil   = ({1'b0, cur_hdr.pkt_len} + 17'd7) >> 3;
  assign seq_expect = `CVITA_SEQ_W'((int'(last_seq) + 1) % `CVITA_SEQ_MOD);

  always_comb begin
    status_d           = '0;
    status_d.hdr       = cur_hdr;
    status_d.vita_time = cur_time;
    status_d.beats     = i_beats;
    status_d.len_err   = (len_ceil != {1'b0, i_beats});
    status_d.time_err  = cur_hdr.has_time && (i_beats < 2);
    status_d.seq_err   = seq_seen && (cur_hdr.seqnum != seq_expect);
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_status_valid <= 1'b0;
      seq_seen       <= 1'b0;
      last_seq       <= '0;
    end else if (i_clear) begin
      o_status_valid <= 1'b0;
      seq_seen       <= 1'b0;
      last_seq       <= '0;
    end else begin
      o_status_valid <= i_pkt_end;
      if (i_pkt_end) begin
        seq_seen <= 1'b1;
        last_seq <= cur_hdr.seqnum;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_pkt_end) begin
      o_status <= status_d;
    end
  end

endmodule

/* hw/cvita_beat_counter.sv */
////////////////////////////////////////////////////////////
// cvita beat counter
// counts accepted lines per packet, pulses at packet end
////////////////////////////////////////////////////////////
`include "cvita_consts.svh"

module cvita_beat_counter (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  logic                    i_clear,
  // accepted beat on the observed stream
  input  logic                    i_beat,
  input  logic                    i_last,
  output logic                    o_pkt_end,
  output logic [`CVITA_LEN_W-1:0] o_beats
);

  // beats already taken in the current packet
  logic [`CVITA_LEN_W-1:0] cnt;
  logic [`CVITA_LEN_W-1:0] cnt_next;

  // saturate instead of wrapping on very long packets
  assign cnt_next = (cnt == '1) ? cnt : cnt + 1'b1;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cnt <= '0;
    end else if (i_clear) begin
      cnt <= '0;
    end else if (i_beat) begin
      if (i_last) begin
        cnt <= '0;
      end else begin
        cnt <= cnt_next;
      end
    end
  end

  // total includes the beat that carries last
  assign o_beats   = cnt_next;
  assign o_pkt_end = i_beat & i_last;

endmodule

/* hw/cvita_hdr_parser.sv */
////////////////////////////////////////////////////////////
// cvita header parser
// passes the stream through and pulls out the header fields
// and, for timed packets, the vita time of the second line
////////////////////////////////////////////////////////////
`include "cvita_consts.svh"

module cvita_hdr_parser import cvita_pkg::*; #(
  // 0: pass-through, fields only valid with their strobe
  // 1: registered stream, header held for the whole packet
  parameter int REGISTER = `CVITA_HDR_REGISTER
) (
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  logic                     i_clear,
  input  logic [`CVITA_DATA_W-1:0] i_tdata,
  input  logic                     i_tlast,
  input  logic                     i_tvalid,
  output logic                     o_tready,
  output logic [`CVITA_DATA_W-1:0] o_tdata,
  output logic                     o_tlast,
  output logic                     o_tvalid,
  input  logic                     i_out_tready,
  output logic                     o_hdr_stb,
  output cvita_hdr_t               o_hdr,
  output logic                     o_time_stb,
  output logic [`CVITA_DATA_W-1:0] o_vita_time
);

  ////////////////////////////////////////////////////////////
  // stream path
  ////////////////////////////////////////////////////////////
  generate
    if (REGISTER != 0) begin : g_reg
      logic [`CVITA_DATA_W:0] stage_out;

      axis_flop_stage #(
        .WIDTH (`CVITA_DATA_W + 1)
      ) u_stage (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_clear (i_clear),
        .i_data  ({i_tlast, i_tdata}),
        .i_valid (i_tvalid),
        .o_ready (o_tready),
        .o_data  (stage_out),
        .o_valid (o_tvalid),
        .i_ready (i_out_tready)
      );

      assign {o_tlast, o_tdata} = stage_out;
    end else begin : g_pass
      assign o_tdata  = i_tdata;
      assign o_tlast  = i_tlast;
      assign o_tvalid = i_tvalid;
      assign o_tready = i_out_tready;
    end
  endgenerate

  ////////////////////////////////////////////////////////////
  // line tracking
  ////////////////////////////////////////////////////////////
  cvita_line_u                line;
  logic                       beat;
  logic                       first_line;
  logic                       read_time;
  cvita_hdr_t                 hdr_reg;
  logic [`CVITA_DATA_W-1:0]   time_reg;

  assign line = o_tdata;
  assign beat = o_tvalid & i_out_tready;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      first_line <= 1'b1;
      read_time  <= 1'b0;
    end else if (i_clear) begin
      first_line <= 1'b1;
      read_time  <= 1'b0;
    end else if (beat) begin
      if (first_line) begin
        first_line <= 1'b0;
        read_time  <= line.hdr.has_time;
      end
      if (read_time) begin
        read_time <= 1'b0;
      end
      // a timed packet that ends on its header never reads a time
      if (o_tlast) begin
        first_line <= 1'b1;
        read_time  <= 1'b0;
      end
    end
  end

  assign o_hdr_stb  = first_line & beat;
  assign o_time_stb = read_time & beat;

  always_ff @(posedge clk) begin
    if (o_hdr_stb) begin
      hdr_reg <= line.hdr;
    end
    if (o_time_stb) begin
      time_reg <= line.vita_time;
    end
  end

  // live line during the strobe, held copy for the rest of the packet
  assign o_hdr       = (o_hdr_stb || REGISTER == 0) ? line.hdr : hdr_reg;
  assign o_vita_time = (o_time_stb || REGISTER == 0) ? line.vita_time : time_reg;

endmodule

/* hw/axis_flop_stage.sv */
////////////////////////////////////////////////////////////
// axis flop stage
// one-entry valid/ready register with full throughput
////////////////////////////////////////////////////////////
module axis_flop_stage #(
  parameter int WIDTH = 65
) (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_clear,
  // upstream side
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_valid,
  output logic             o_ready,
  // downstream side
  output logic [WIDTH-1:0] o_data,
  output logic             o_valid,
  input  logic             i_ready
);

  // room when empty or when the held beat leaves this cycle
  assign o_ready = ~o_valid | i_ready;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else if (i_clear) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  // payload only moves on an accepted input beat
  always_ff @(posedge clk) begin
    if (o_ready && i_valid) begin
      o_data <= i_data;
    end
  end

endmodule

/* hw/cvita_pkg.sv */
////////////////////////////////////////////////////////////
// cvita types
// header layout, line views and the per-packet status record
////////////////////////////////////////////////////////////
`include "cvita_consts.svh"

package cvita_pkg;

  // first line of every cvita packet, msb first
  typedef struct packed {
    logic [1:0]                 pkt_type;
    logic                       has_time;
    logic                       eob;
    logic [`CVITA_SEQ_W-1:0]    seqnum;
    // length in bytes
    logic [`CVITA_LEN_W-1:0]    pkt_len;
    logic [31:0]                sid;
  } cvita_hdr_t;

  // a line is either a header or, on the second beat of a
  // timed packet, the 64-bit vita time
  typedef union packed {
    cvita_hdr_t                 hdr;
    logic [`CVITA_DATA_W-1:0]   vita_time;
  } cvita_line_u;

  // one record per packet, emitted at packet end
  typedef struct packed {
    cvita_hdr_t                 hdr;
    logic [`CVITA_DATA_W-1:0]   vita_time;
    logic [`CVITA_LEN_W-1:0]    beats;
    logic                       len_err;
    logic                       time_err;
    logic                       seq_err;
  } cvita_status_t;

endpackage

/* include/cvita_consts.svh */
////////////////////////////////////////////////////////////
// cvita constants
// line, field widths and build options shared by the
// cvita inspection blocks
////////////////////////////////////////////////////////////
`ifndef CVITA_CONSTS_SVH
`define CVITA_CONSTS_SVH

// one cvita line per stream beat
`define CVITA_DATA_W 64

// 1 keeps header and time registered for the whole packet
`define CVITA_HDR_REGISTER 1

// header field widths
`define CVITA_SEQ_W 12
`define CVITA_LEN_W 16

// sequence numbers wrap at this value
`define CVITA_SEQ_MOD 4096

`endif
